//--- files.f
+incdir+rtl
+incdir+test
rtl/idct_pkg.sv
rtl/block_ram.sv
rtl/mac_pair.sv
rtl/idct_sequencer.sv
rtl/idct_top.sv
test/tb_idct.sv

//--- rtl/block_ram.sv
`timescale 1ns/1ps

module block_ram #(
	parameter int WIDTH = 16,
	parameter int DEPTH = 64
) (
	input  logic                     Clock,
	input  logic                     wr_en,
	input  logic [$clog2(DEPTH)-1:0] wr_addr,
	input  logic [WIDTH-1:0]         wr_data,
	input  logic [$clog2(DEPTH)-1:0] rd_addr,
	output logic [WIDTH-1:0]         rd_data
);

	logic [WIDTH-1:0] mem [DEPTH];

	always_ff @(posedge Clock) begin
		if (wr_en) begin
			mem[wr_addr] <= wr_data;
		end
		rd_data <= mem[rd_addr];   // registered read, old data on collision
	end

endmodule

//--- rtl/idct_pkg.sv
`include "idct_settings.svh"

package idct_pkg;

	typedef enum logic [2:0] {
		IDLE,
		LOAD,
		ROW_PASS,
		ROW_DRAIN,
		COL_PASS,
		COL_DRAIN
	} idct_state_e;

	typedef logic signed [`COEF_WIDTH-1:0] coef_t;
	typedef logic signed [`T_WIDTH-1:0]    tval_t;
	typedef logic [7:0]                    pixel_t;

	typedef struct packed {
		logic [5:0] index;   // row*8 + col
		coef_t      value;
	} coef_in_t;

	// one T buffer entry, T[i][j] and T[i][j+1]
	typedef struct packed {
		tval_t lane_1;
		tval_t lane_0;
	} tpair_t;

	typedef struct packed {
		logic [2:0] row;     // row of pixel_0
		logic [2:0] col;
		pixel_t     pixel_0;
		pixel_t     pixel_1; // one row below
	} pixel_pair_out_t;

	// C[k][j], 2048*cos((2j+1)k*pi/16), k=0 row scaled by 1/sqrt(2)
	localparam logic signed [`CMAT_WIDTH-1:0] COS_TABLE [`BLOCK_DIM][`BLOCK_DIM] = '{
		'{ 1448,  1448,  1448,  1448,  1448,  1448,  1448,  1448},
		'{ 2008,  1702,  1137,   399,  -399, -1137, -1702, -2008},
		'{ 1892,   783,  -783, -1892, -1892,  -783,   783,  1892},
		'{ 1702,  -399, -2008, -1137,  1137,  2008,   399, -1702},
		'{ 1448, -1448, -1448,  1448,  1448, -1448, -1448,  1448},
		'{ 1137, -2008,   399,  1702, -1702,  -399,  2008, -1137},
		'{  783, -1892,  1892,  -783,  -783,  1892, -1892,   783},
		'{  399, -1137,  1702, -2008,  2008, -1702,  1137,  -399}
	};

endpackage

//--- rtl/idct_sequencer.sv
`timescale 1ns/1ps
`include "idct_settings.svh"

module idct_sequencer
	import idct_pkg::*;
(
	input  logic                         Clock,
	input  logic                         Resetn,
	input  logic                         coef_valid,
	input  coef_in_t                     coef_in,
	input  coef_t                        q_rd_data,
	input  tpair_t                       t_rd_data,
	input  logic                         sum_valid,
	input  tpair_t                       t_out,
	input  pixel_t                       pix_0,
	input  pixel_t                       pix_1,
	output logic                         q_wr_en,
	output logic [5:0]                   q_wr_addr,
	output coef_t                        q_wr_data,
	output logic [5:0]                   q_rd_addr,
	output logic                         t_wr_en,
	output logic [4:0]                   t_wr_addr,
	output tpair_t                       t_wr_data,
	output logic [4:0]                   t_rd_addr,
	output logic                         mac_valid,
	output logic                         mac_first,
	output logic                         mac_last,
	output logic signed [`ACC_WIDTH-1:0]  operand,
	output logic signed [`CMAT_WIDTH-1:0] coef_0,
	output logic signed [`CMAT_WIDTH-1:0] coef_1,
	output logic                         pix_valid,
	output pixel_pair_out_t              pix_out,
	output logic                         done,
	output logic                         busy
);

	idct_state_e state;
	logic [5:0]  load_cnt;
	logic [7:0]  step;       // {pair, k}
	logic        accept;
	logic        row_phase;
	logic        col_phase;
	logic        s1_valid;   // read data valid this cycle
	logic        s1_col;
	logic [7:0]  s1_step;
	logic [2:0]  s1_k;
	logic [4:0]  s1_pair;
	logic [4:0]  s2_pair;
	logic [4:0]  s3_pair;    // label of the sum on sum_valid
	logic [1:0]  tab_sel;
	tval_t       t_half;

	assign accept = coef_valid && (state == IDLE || state == LOAD);
	assign row_phase = (state == ROW_PASS) || (state == ROW_DRAIN);
	assign col_phase = (state == COL_PASS) || (state == COL_DRAIN);
	assign busy = row_phase || col_phase;

	// coefficient loading
	assign q_wr_en = accept;
	assign q_wr_addr = coef_in.index;
	assign q_wr_data = coef_in.value;

	// issue stage
	assign q_rd_addr = {step[7:5], step[2:0]};   // Q[i][k], i = pair/4
	assign t_rd_addr = {step[2:0], step[5:4]};   // entry of T[k][j], j = pair%8

	// operand stage, one cycle after the read
	assign s1_k = s1_step[2:0];
	assign s1_pair = s1_step[7:3];
	assign tab_sel = s1_col ? s1_pair[4:3] : s1_pair[1:0];   // i/2 or j/2
	assign t_half = s1_pair[0] ? t_rd_data.lane_1 : t_rd_data.lane_0;

	assign mac_valid = s1_valid;
	assign mac_first = s1_valid && (s1_k == 3'd0);
	assign mac_last = s1_valid && (s1_k == 3'd7);
	assign operand = s1_col ? `ACC_WIDTH'(t_half) : `ACC_WIDTH'(q_rd_data);
	assign coef_0 = COS_TABLE[s1_k][{tab_sel, 1'b0}];
	assign coef_1 = COS_TABLE[s1_k][{tab_sel, 1'b1}];

	// row results go back into the T buffer
	assign t_wr_en = sum_valid && row_phase;
	assign t_wr_addr = s3_pair;
	assign t_wr_data = t_out;

	always_ff @(posedge Clock or negedge Resetn) begin
		if (!Resetn) begin
			state <= IDLE;
			load_cnt <= '0;
			step <= '0;
			s1_valid <= 1'b0;
			s1_col <= 1'b0;
			pix_valid <= 1'b0;
			done <= 1'b0;
		end else begin
			s1_valid <= (state == ROW_PASS) || (state == COL_PASS);
			s1_col <= (state == COL_PASS);
			pix_valid <= sum_valid && col_phase;
			done <= 1'b0;
			case (state)
				IDLE, LOAD: begin
					if (accept) begin
						load_cnt <= load_cnt + 6'd1;   // wraps after the 64th
						step <= '0;
						state <= (load_cnt == 6'd63) ? ROW_PASS : LOAD;
					end
				end
				ROW_PASS: begin
					step <= step + 8'd1;
					if (step == 8'd255) begin
						state <= ROW_DRAIN;
					end
				end
				ROW_DRAIN: begin
					// only the last row sum shows up here, its write lands at this edge
					if (sum_valid) begin
						state <= COL_PASS;
					end
				end
				COL_PASS: begin
					step <= step + 8'd1;
					if (step == 8'd255) begin
						state <= COL_DRAIN;
					end
				end
				COL_DRAIN: begin
					if (pix_valid) begin   // last pair just left
						done <= 1'b1;
						state <= IDLE;
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

	always_ff @(posedge Clock) begin
		s1_step <= step;
		s2_pair <= s1_pair;
		s3_pair <= s2_pair;
		pix_out.row <= {s3_pair[4:3], 1'b0};
		pix_out.col <= s3_pair[2:0];
		pix_out.pixel_0 <= pix_0;
		pix_out.pixel_1 <= pix_1;
	end

endmodule

//--- rtl/idct_settings.svh
`ifndef IDCT_SETTINGS_SVH
`define IDCT_SETTINGS_SVH

// input coefficient and cosine entry widths
`define COEF_WIDTH 16
`define CMAT_WIDTH 13

// stored T element, and the accumulator that must never overflow
`define T_WIDTH    24
`define ACC_WIDTH  40

// scaling after each pass
`define ROW_SHIFT  8
`define COL_SHIFT  16

// block geometry and output clip
`define BLOCK_DIM  8
`define PIXEL_MAX  255

`endif

//--- rtl/idct_top.sv
`timescale 1ns/1ps
`include "idct_settings.svh"

module idct_top
	import idct_pkg::*;
(
	input  logic            Clock,
	input  logic            Resetn,
	input  logic            coef_valid,
	input  coef_in_t        coef_in,
	output logic            pix_valid,
	output pixel_pair_out_t pix_out,
	output logic            done,
	output logic            busy
);

	localparam int Q_DEPTH = `BLOCK_DIM * `BLOCK_DIM;
	localparam int T_DEPTH = Q_DEPTH / 2;   // two T elements per entry

	logic                         q_wr_en;
	logic [5:0]                   q_wr_addr;
	coef_t                        q_wr_data;
	logic [5:0]                   q_rd_addr;
	coef_t                        q_rd_data;
	logic                         t_wr_en;
	logic [4:0]                   t_wr_addr;
	tpair_t                       t_wr_data;
	logic [4:0]                   t_rd_addr;
	tpair_t                       t_rd_data;
	logic                         mac_valid;
	logic                         mac_first;
	logic                         mac_last;
	logic signed [`ACC_WIDTH-1:0]  operand;
	logic signed [`CMAT_WIDTH-1:0] coef_0;
	logic signed [`CMAT_WIDTH-1:0] coef_1;
	logic                         sum_valid;
	tpair_t                       t_out;
	pixel_t                       pix_0;
	pixel_t                       pix_1;

	block_ram #(.WIDTH($bits(coef_t)), .DEPTH(Q_DEPTH)) q_buf_i (
		.Clock   (Clock),
		.wr_en   (q_wr_en),
		.wr_addr (q_wr_addr),
		.wr_data (q_wr_data),
		.rd_addr (q_rd_addr),
		.rd_data (q_rd_data)
	);

	block_ram #(.WIDTH($bits(tpair_t)), .DEPTH(T_DEPTH)) t_buf_i (
		.Clock   (Clock),
		.wr_en   (t_wr_en),
		.wr_addr (t_wr_addr),
		.wr_data (t_wr_data),
		.rd_addr (t_rd_addr),
		.rd_data (t_rd_data)
	);

	mac_pair mac_pair_i (
		.Clock     (Clock),
		.Resetn    (Resetn),
		.mac_valid (mac_valid),
		.mac_first (mac_first),
		.mac_last  (mac_last),
		.operand   (operand),
		.coef_0    (coef_0),
		.coef_1    (coef_1),
		.sum_valid (sum_valid),
		.t_out     (t_out),
		.pix_0     (pix_0),
		.pix_1     (pix_1)
	);

	idct_sequencer idct_sequencer_i (
		.Clock      (Clock),
		.Resetn     (Resetn),
		.coef_valid (coef_valid),
		.coef_in    (coef_in),
		.q_rd_data  (q_rd_data),
		.t_rd_data  (t_rd_data),
		.sum_valid  (sum_valid),
		.t_out      (t_out),
		.pix_0      (pix_0),
		.pix_1      (pix_1),
		.q_wr_en    (q_wr_en),
		.q_wr_addr  (q_wr_addr),
		.q_wr_data  (q_wr_data),
		.q_rd_addr  (q_rd_addr),
		.t_wr_en    (t_wr_en),
		.t_wr_addr  (t_wr_addr),
		.t_wr_data  (t_wr_data),
		.t_rd_addr  (t_rd_addr),
		.mac_valid  (mac_valid),
		.mac_first  (mac_first),
		.mac_last   (mac_last),
		.operand    (operand),
		.coef_0     (coef_0),
		.coef_1     (coef_1),
		.pix_valid  (pix_valid),
		.pix_out    (pix_out),
		.done       (done),
		.busy       (busy)
	);

endmodule

//--- rtl/mac_pair.sv
`timescale 1ns/1ps
`include "idct_settings.svh"

module mac_pair
	import idct_pkg::*;
(
	input  logic                         Clock,
	input  logic                         Resetn,
	input  logic                         mac_valid,
	input  logic                         mac_first,
	input  logic                         mac_last,
	input  logic signed [`ACC_WIDTH-1:0]  operand,
	input  logic signed [`CMAT_WIDTH-1:0] coef_0,
	input  logic signed [`CMAT_WIDTH-1:0] coef_1,
	output logic                         sum_valid,
	output tpair_t                       t_out,
	output pixel_t                       pix_0,
	output pixel_t                       pix_1
);

	typedef logic signed [`ACC_WIDTH-1:0] acc_t;

	acc_t coef_ext [2];
	acc_t acc [2];
	acc_t acc_next [2];
	acc_t fin [2];   // finished sums waiting for scaling
	logic fin_valid;

	// column scaling, then clamp into the pixel range
	function automatic pixel_t clip_pixel(input acc_t sum);
		acc_t   scaled;
		pixel_t result;
		scaled = sum >>> `COL_SHIFT;
		if (scaled < 0) begin
			result = '0;
		end else if (scaled > `PIXEL_MAX) begin
			result = pixel_t'(`PIXEL_MAX);
		end else begin
			result = pixel_t'(scaled);
		end
		return result;
	endfunction

	assign coef_ext[0] = acc_t'(coef_0);
	assign coef_ext[1] = acc_t'(coef_1);

	always_comb begin
		for (int l = 0; l < 2; l++) begin
			acc_next[l] = (mac_first ? acc_t'(0) : acc[l])   // restart on first
				+ operand * coef_ext[l];
		end
	end

	always_ff @(posedge Clock) begin
		if (mac_valid) begin
			acc <= acc_next;
			if (mac_last) begin
				fin <= acc_next;
			end
		end
		t_out.lane_0 <= tval_t'(fin[0] >>> `ROW_SHIFT);
		t_out.lane_1 <= tval_t'(fin[1] >>> `ROW_SHIFT);
		pix_0 <= clip_pixel(fin[0]);
		pix_1 <= clip_pixel(fin[1]);
	end

	always_ff @(posedge Clock or negedge Resetn) begin
		if (!Resetn) begin
			fin_valid <= 1'b0;
			sum_valid <= 1'b0;
		end else begin
			fin_valid <= mac_valid && mac_last;
			sum_valid <= fin_valid;   // two cycles after the last product
		end
	end

endmodule

//--- run.sh
#!/bin/sh
# build and run the IDCT testbench with Verilator, from the project root

cd "$(dirname "$0")" || exit 1

LOG=sim.log

rm -rf obj_dir
verilator --binary --timing --assert -f files.f --top-module tb_idct -o tb_idct
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/tb_idct > "$LOG" 2>&1
sim_status=$?
cat "$LOG"

if grep -q "Some tests failed" "$LOG"; then
	exit 1
fi
if [ $sim_status -ne 0 ]; then
	echo "simulation exited with status $sim_status"
	exit 1
fi
exit 0

//--- test/idct_ref.svh
`ifndef IDCT_REF_SVH
`define IDCT_REF_SVH

int     coef_blk [64];     // model input, index row*8+col
longint t_model [8][8];    // row pass result
int     s_model [8][8];    // clipped pixels

// T = Q * C, floor shift after the sum
task automatic compute_t();
	longint sum;
	for (int i = 0; i < `BLOCK_DIM; i++) begin
		for (int j = 0; j < `BLOCK_DIM; j++) begin
			sum = 0;
			for (int k = 0; k < `BLOCK_DIM; k++) begin
				sum += longint'(coef_blk[i * `BLOCK_DIM + k]) * longint'(COS_TABLE[k][j]);
			end
			t_model[i][j] = sum >>> `ROW_SHIFT;
		end
	end
endtask

// S = C transposed * T, then clip to the pixel range
task automatic compute_s();
	longint sum;
	for (int i = 0; i < `BLOCK_DIM; i++) begin
		for (int j = 0; j < `BLOCK_DIM; j++) begin
			sum = 0;
			for (int k = 0; k < `BLOCK_DIM; k++) begin
				sum += longint'(COS_TABLE[k][i]) * t_model[k][j];
			end
			sum = sum >>> `COL_SHIFT;
			if (sum < longint'(0)) begin
				s_model[i][j] = 0;
			end else if (sum > longint'(`PIXEL_MAX)) begin
				s_model[i][j] = `PIXEL_MAX;
			end else begin
				s_model[i][j] = int'(sum);
			end
		end
	end
endtask

`endif

//--- test/tb_idct.sv
`timescale 1ns/1ps
`include "idct_settings.svh"

module tb_idct
	import idct_pkg::*;
();

	localparam int NUM_BLOCKS = 10;
	localparam int CYCLES_PER_BLOCK = 700;   // load plus both passes, with margin
	localparam int TIMEOUT_CYCLES = NUM_BLOCKS * CYCLES_PER_BLOCK + 16;

	logic            Clock;
	logic            Resetn;
	logic            coef_valid;
	coef_in_t        coef_in;
	logic            pix_valid;
	pixel_pair_out_t pix_out;
	logic            done;
	logic            busy;

	pixel_pair_out_t exp_q [$];
	pixel_pair_out_t exp_head;   // pair expected on the current pix_valid
	int              cycle_count = 0;

	`include "idct_ref.svh"

	idct_top dut_i (
		.Clock      (Clock),
		.Resetn     (Resetn),
		.coef_valid (coef_valid),
		.coef_in    (coef_in),
		.pix_valid  (pix_valid),
		.pix_out    (pix_out),
		.done       (done),
		.busy       (busy)
	);

	initial begin
		Clock = 1'b0;
		forever #4 Clock = ~Clock;
	end

	task automatic stop_with_error(input string what);
		$display("%s", what);
		$display("Some tests failed");
		$fatal(1, "stopping at first error");
	endtask

	always @(posedge Clock) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			stop_with_error($sformatf("timed out after %0d cycles, done never arrived",
				cycle_count));
		end
	end

	pixel_0_check: assert property (@(posedge Clock) disable iff (!Resetn)
		pix_valid |-> (pix_out.pixel_0 == exp_head.pixel_0))
		else stop_with_error($sformatf("[FAIL] pix_out.pixel_0 expected %h got %h",
			$sampled(exp_head.pixel_0), $sampled(pix_out.pixel_0)));

	pixel_1_check: assert property (@(posedge Clock) disable iff (!Resetn)
		pix_valid |-> (pix_out.pixel_1 == exp_head.pixel_1))
		else stop_with_error($sformatf("[FAIL] pix_out.pixel_1 expected %h got %h",
			$sampled(exp_head.pixel_1), $sampled(pix_out.pixel_1)));

	row_check: assert property (@(posedge Clock) disable iff (!Resetn)
		pix_valid |-> (pix_out.row == exp_head.row))
		else stop_with_error($sformatf("[FAIL] pix_out.row expected %h got %h",
			$sampled(exp_head.row), $sampled(pix_out.row)));

	col_check: assert property (@(posedge Clock) disable iff (!Resetn)
		pix_valid |-> (pix_out.col == exp_head.col))
		else stop_with_error($sformatf("[FAIL] pix_out.col expected %h got %h",
			$sampled(exp_head.col), $sampled(pix_out.col)));

	task automatic fill_random();
		for (int n = 0; n < 64; n++) begin
			coef_blk[n] = int'($urandom_range(4096, 0)) - 2048;   // -2048..2048
		end
	endtask

	task automatic fill_dc(input int dc);
		for (int n = 0; n < 64; n++) begin
			coef_blk[n] = 0;
		end
		coef_blk[0] = dc;
	endtask

	// 32 pairs in output order, from the model or one flat level
	task automatic build_expected(input bit use_model, input pixel_t level);
		pixel_pair_out_t pair;
		exp_q.delete();
		for (int p = 0; p < 32; p++) begin
			pair.row = 3'(2 * (p / 8));
			pair.col = 3'(p % 8);
			pair.pixel_0 = use_model ? pixel_t'(s_model[2 * (p / 8)][p % 8]) : level;
			pair.pixel_1 = use_model ? pixel_t'(s_model[2 * (p / 8) + 1][p % 8]) : level;
			exp_q.push_back(pair);
		end
	endtask

	// entered and left 1 ns after a rising edge
	task automatic load_block(input bit shuffled);
		int order [64];
		int pick;
		int tmp;
		for (int n = 0; n < 64; n++) begin
			order[n] = n;
		end
		if (shuffled) begin
			for (int n = 63; n > 0; n--) begin
				pick = int'($urandom_range(n, 0));
				tmp = order[n];
				order[n] = order[pick];
				order[pick] = tmp;
			end
		end
		for (int n = 0; n < 64; n++) begin
			assert (!busy) else stop_with_error("busy went high before the 64th coefficient");
			coef_valid = 1'b1;
			coef_in.index = 6'(order[n]);
			coef_in.value = coef_t'(coef_blk[order[n]]);
			@(posedge Clock);
			#1;
		end
		coef_valid = 1'b0;
	endtask

	task automatic wait_for_done(input bit junk);
		bit finished;
		finished = 1'b0;
		while (!finished) begin
			if (done) begin
				assert (exp_q.size() == 0)
					else stop_with_error("done arrived while pairs were still expected");
				assert (!busy) else stop_with_error("busy still high while done is high");
				coef_valid = 1'b0;
				finished = 1'b1;
			end else begin
				assert (busy) else stop_with_error("busy dropped before done");
				if (pix_valid) begin
					assert (exp_q.size() > 0)
						else stop_with_error("pix_valid arrived after all 32 pairs");
					exp_head = exp_q.pop_front();
				end
				if (junk) begin   // these must all be ignored
					coef_valid = 1'($urandom_range(1, 0));
					coef_in.index = 6'($urandom_range(63, 0));
					coef_in.value = coef_t'($urandom_range(65535, 0));
				end
				@(posedge Clock);
				#1;
			end
		end
	endtask

	task automatic run_block(input bit shuffled, input bit junk);
		load_block(shuffled);
		wait_for_done(junk);
	endtask

	task automatic model_block();
		compute_t();
		compute_s();
		build_expected(1'b1, 8'h00);
	endtask

	initial begin
		void'($urandom(23365));
		Resetn = 1'b0;
		coef_valid = 1'b0;
		coef_in = '0;
		exp_head = '0;
		repeat (5) @(posedge Clock);
		#1;
		Resetn = 1'b1;
		@(posedge Clock);
		#1;
		assert (!pix_valid && !done && !busy)
			else stop_with_error("outputs not idle after reset");

		fill_random();
		model_block();
		run_block(1'b0, 1'b0);

		// DC only, every pixel equal
		fill_dc(1000);
		compute_t();
		compute_s();
		build_expected(1'b0, pixel_t'(s_model[0][0]));
		run_block(1'b0, 1'b0);
		fill_dc(16000);   // clips high
		build_expected(1'b0, 8'hff);
		run_block(1'b0, 1'b0);
		fill_dc(-16000);  // clips low
		build_expected(1'b0, 8'h00);
		run_block(1'b0, 1'b0);

		// same block in order, then shuffled
		fill_random();
		model_block();
		run_block(1'b0, 1'b0);
		model_block();
		run_block(1'b1, 1'b0);

		// strobes while busy, then the following blocks
		fill_random();
		model_block();
		run_block(1'b0, 1'b1);
		repeat (3) begin
			fill_random();
			model_block();
			run_block(1'b0, 1'b0);
		end

		$display("All tests passed");
		$finish;
	end

endmodule
